// ==== dcache.f ====
dcache_geom_pkg.sv
dcache_ctrl_pkg.sv
way_if.sv
dcache_ram.sv
dcache_way.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
dcache_tb.sv

// ==== dcache_ctrl.sv ====
// cache controller FSM with lru storage, cpu and memory four-phase handshakes and way writes
`default_nettype none
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cpu_req,
    input  logic                         cpu_we,
    input  dcache_geom_pkg::addr_t       cpu_addr,
    output logic                         cpu_ack,
    output dcache_geom_pkg::word_t       cpu_rdata,
    output logic                         mem_req,
    output logic                         mem_we,
    output dcache_geom_pkg::addr_t       mem_addr,
    output dcache_geom_pkg::line_t       mem_wdata,
    input  logic                         mem_ack,
    input  dcache_geom_pkg::line_t       mem_rdata,
    way_if.ctrl                          ways [dcache_geom_pkg::NUM_WAYS],
    input  dcache_ctrl_pkg::lookup_res_t res,
    output dcache_geom_pkg::way_t        lru
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    ctrl_state_t         state;
    way_t                fill_way;   // victim latched at the miss
    logic [NUM_WAYS-1:0] wr_en;
    logic                wr_dirty;
    line_t               wr_line;
    logic                lru_wr;
    index_t              index;
    tag_t                tag;
    addr_t               fill_addr;

    assign index     = addr_index(cpu_addr);
    assign tag       = addr_tag(cpu_addr);
    assign fill_addr = line_addr(tag, index);

    // write hit merges the cpu word, fill stores the fetched line clean
    always_comb begin
        wr_en    = '0;
        wr_dirty = 1'b0;
        wr_line  = mem_rdata;
        if (state == COMPARE && res.hit && cpu_we) begin
            wr_en[res.hit_way] = 1'b1;
            wr_dirty           = 1'b1;
            wr_line            = res.wr_line;
        end else if (state == FILL_REQ && mem_ack) begin
            wr_en[fill_way] = 1'b1;
        end
    end

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way_wr
        assign ways[g].index    = index;
        assign ways[g].req_tag  = tag;
        assign ways[g].wr_en    = wr_en[g];
        assign ways[g].wr_tag   = tag;
        assign ways[g].wr_dirty = wr_dirty;
        assign ways[g].wr_line  = wr_line;
    end

    assign lru_wr = (state == COMPARE) && res.hit;

    dcache_ram #(
        .payload_t (way_t),
        .DEPTH     (NUM_SETS)
    ) u_lru (
        .clk     (clk),
        .addr    (index),
        .wr_en   (lru_wr),
        .wr_data (~res.hit_way),  // point at the other way
        .rd_data (lru)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= COMPARE;  // storage read lands this cycle
                end
                COMPARE: begin
                    if (res.hit) begin
                        state <= ACK;
                    end else if (res.victim_dirty) begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b1;
                        state   <= WB_REQ;
                    end else begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= FILL_REQ;
                    end
                end
                WB_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= WB_REL;
                    end
                end
                WB_REL: begin
                    if (!mem_ack) begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b0;
                        state   <= FILL_REQ;
                    end
                end
                FILL_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;  // way written at this edge
                        state   <= FILL_REL;
                    end
                end
                FILL_REL: begin
                    if (!mem_ack) begin
                        state <= LOOKUP;  // replay as a hit
                    end
                end
                ACK: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request fields and read data
    always_ff @(posedge clk) begin
        if (state == COMPARE) begin
            cpu_rdata <= res.rd_word;
            if (!res.hit) begin
                fill_way  <= res.victim_way;
                mem_addr  <= res.victim_dirty ? res.victim_addr : fill_addr;
                mem_wdata <= res.victim_line;
            end
        end else if (state == WB_REL && !mem_ack) begin
            mem_addr <= fill_addr;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_ctrl_pkg.sv ====
// controller state encoding and the lookup result passed from lookup to controller
`default_nettype none

package dcache_ctrl_pkg;

    localparam int STATE_W = 3;

    typedef enum logic [STATE_W-1:0] {
        IDLE,       // waiting for cpu_req
        LOOKUP,     // set index presented, storage read in flight
        COMPARE,    // ways resolved, hit or pick victim
        WB_REQ,     // dirty victim out, waiting for mem_ack
        WB_REL,     // waiting for mem_ack to drop
        FILL_REQ,   // line read out, way written on mem_ack
        FILL_REL,   // waiting for mem_ack to drop, then replay
        ACK         // cpu handshake
    } ctrl_state_t;

    typedef struct packed {
        logic                   hit;           // any way matched
        dcache_geom_pkg::way_t  hit_way;
        dcache_geom_pkg::word_t rd_word;       // word at the offset of the hit line
        dcache_geom_pkg::line_t wr_line;       // hit line with cpu word merged in
        dcache_geom_pkg::way_t  victim_way;
        logic                   victim_dirty;  // valid and dirty
        dcache_geom_pkg::addr_t victim_addr;   // rebuilt from stored tag and index
        dcache_geom_pkg::line_t victim_line;
    } lookup_res_t;

endpackage

`default_nettype wire

// ==== dcache_geom_pkg.sv ====
// address geometry and basic data types, imported by every cache module and the interface
`default_nettype none

package dcache_geom_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 2;   // word within a line
    localparam int BYTE_W     = 2;   // byte within a word
    localparam int NUM_SETS   = 16;  // kept small so random traffic evicts often
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
    localparam int NUM_WAYS   = 2;   // one lru bit per set only covers two ways
    localparam int LINE_W     = LINE_WORDS * WORD_W;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [LINE_W-1:0]            line_t;   // word 0 in the low bits
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]  way_t;

    function automatic tag_t addr_tag(input addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(input addr_t a);
        return a[OFFSET_W+BYTE_W +: INDEX_W];
    endfunction

    function automatic offset_t addr_offset(input addr_t a);
        return a[BYTE_W +: OFFSET_W];
    endfunction

    // base address of a line from its tag and set
    function automatic addr_t line_addr(input tag_t t, input index_t i);
        return {t, i, {(OFFSET_W + BYTE_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== dcache_lookup.sv ====
// resolves both ways into hit, read word, merged write line and the victim for a miss
`default_nettype none
`timescale 1ns/1ns

module dcache_lookup (
    way_if.lookup                        ways [dcache_geom_pkg::NUM_WAYS],
    input  dcache_geom_pkg::addr_t       cpu_addr,
    input  dcache_geom_pkg::word_t       cpu_wdata,
    input  dcache_geom_pkg::way_t        lru,
    output dcache_ctrl_pkg::lookup_res_t res
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    logic [NUM_WAYS-1:0] valid_v;
    logic [NUM_WAYS-1:0] dirty_v;
    logic [NUM_WAYS-1:0] match_v;
    tag_t                tag_v  [NUM_WAYS];
    line_t               line_v [NUM_WAYS];

    offset_t offset;
    index_t  index;
    line_t   hit_line;

    // gather each way's read results into vectors
    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way_rd
        assign valid_v[g] = ways[g].rd_valid;
        assign dirty_v[g] = ways[g].rd_dirty;
        assign match_v[g] = ways[g].match;
        assign tag_v[g]   = ways[g].rd_tag;
        assign line_v[g]  = ways[g].rd_line;
    end

    assign offset = addr_offset(cpu_addr);
    assign index  = addr_index(cpu_addr);

    always_comb begin
        res.hit     = |match_v;
        res.hit_way = '0;
        hit_line    = line_v[0];
        // walk down so the lowest matching way wins
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match_v[w]) begin
                res.hit_way = way_t'(w);
                hit_line    = line_v[w];
            end
        end

        res.rd_word = hit_line[offset*WORD_W +: WORD_W];
        res.wr_line = hit_line;
        res.wr_line[offset*WORD_W +: WORD_W] = cpu_wdata;

        // first invalid way from way 0, else the lru way
        res.victim_way = lru;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_v[w]) begin
                res.victim_way = way_t'(w);
            end
        end

        res.victim_dirty = valid_v[res.victim_way] && dirty_v[res.victim_way];
        res.victim_addr  = line_addr(tag_v[res.victim_way], index);
        res.victim_line  = line_v[res.victim_way];
    end

endmodule

`default_nettype wire

// ==== dcache_ram.sv ====
// synchronous single-port storage array, one entry per set, used for line data and lru bits
`default_nettype none
`timescale 1ns/1ns

module dcache_ram #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic                    clk,
    input  dcache_geom_pkg::index_t addr,
    input  logic                    wr_en,
    input  payload_t                wr_data,
    output payload_t                rd_data
);

    payload_t mem [DEPTH];

    // write-first so a write shows up on the read port at the same edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
            rd_data   <= wr_data;
        end else begin
            rd_data   <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== dcache_tb.sv ====
// self-checking testbench for dcache_top, random cpu traffic against a reference cache model
`default_nettype none
`timescale 1ns/1ns

module dcache_tb;
    import dcache_geom_pkg::*;

    localparam addr_t MEM_BASE       = 32'h8000_1000;  // aligned to a full pass over the sets
    localparam int    WINDOW_LINES   = 64;
    localparam int    WINDOW_WORDS   = WINDOW_LINES * LINE_WORDS;
    localparam int    NUM_RANDOM     = 400;
    localparam int    MAX_DELAY      = 5;
    localparam int    TOTAL_OPS      = NUM_RANDOM + WINDOW_WORDS + 32;
    localparam int    MEM_TXN_CYCLES = 2 * MAX_DELAY + 4;
    localparam int    TIMEOUT_CYCLES = TOTAL_OPS * (10 + 2 * MEM_TXN_CYCLES) * 2;

    logic  clk;
    logic  reset;
    logic  cpu_req;
    logic  cpu_we;
    addr_t cpu_addr;
    word_t cpu_wdata;
    logic  cpu_ack;
    word_t cpu_rdata;
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_ack;
    line_t mem_rdata;

    line_t mem_lines [WINDOW_LINES];  // memory behind the responder
    line_t ref_mem   [WINDOW_LINES];  // memory as the model sees it

    // reference cache state
    logic  m_valid [NUM_WAYS][NUM_SETS];
    logic  m_dirty [NUM_WAYS][NUM_SETS];
    tag_t  m_tag   [NUM_WAYS][NUM_SETS];
    line_t m_line  [NUM_WAYS][NUM_SETS];
    way_t  m_lru   [NUM_SETS];

    // memory transactions the model predicts in order
    logic  exp_we    [$];
    addr_t exp_addr  [$];
    line_t exp_line  [$];
    int    exp_d_ack [$];
    int    exp_d_rel [$];

    logic [WINDOW_WORDS-1:0] touched;
    logic [31:0]             lcg_state;
    int                      cycle_cnt = 0;

    dcache_top uut (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("CHECKS FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;  // odd multiplier keeps every address distinct
    endfunction

    function automatic line_t fill_line(input addr_t base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*WORD_W +: WORD_W] = fill_word(base + addr_t'(w * 4));
        end
        return l;
    endfunction

    function automatic int line_slot(input addr_t a);
        return int'((a - MEM_BASE) >> (OFFSET_W + BYTE_W));
    endfunction

    function automatic addr_t word_addr(input int widx);
        return MEM_BASE + addr_t'(widx * 4);
    endfunction

    task automatic stop_on_error();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic protocol_error(input string msg);
        $display("%s", msg);
        stop_on_error();
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic expect_mem(input logic we, input addr_t a, input line_t l);
        exp_we.push_back(we);
        exp_addr.push_back(a);
        exp_line.push_back(l);
        exp_d_ack.push_back(rand_below(MAX_DELAY + 1));
        exp_d_rel.push_back(rand_below(MAX_DELAY + 1));
    endtask

    // two-way write-back cache with first invalid way else lru victim
    task automatic model_access(input addr_t a, input logic we, input word_t wd,
                                output word_t rd, output logic hit);
        index_t  idx;
        tag_t    tg;
        offset_t off;
        way_t    w;
        addr_t   vaddr;
        idx = a[BYTE_W+OFFSET_W +: INDEX_W];
        tg  = a[ADDR_W-1 -: TAG_W];
        off = a[BYTE_W +: OFFSET_W];
        hit = 1'b0;
        w   = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (m_valid[i][idx] && m_tag[i][idx] == tg) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            w = m_lru[idx];
            for (int i = NUM_WAYS - 1; i >= 0; i--) begin
                if (!m_valid[i][idx]) begin
                    w = way_t'(i);
                end
            end
            if (m_valid[w][idx] && m_dirty[w][idx]) begin
                vaddr = {m_tag[w][idx], idx, {(OFFSET_W + BYTE_W){1'b0}}};
                expect_mem(1'b1, vaddr, m_line[w][idx]);
                ref_mem[line_slot(vaddr)] = m_line[w][idx];
            end
            expect_mem(1'b0, {a[ADDR_W-1:OFFSET_W+BYTE_W], {(OFFSET_W + BYTE_W){1'b0}}}, '0);
            m_line[w][idx]  = ref_mem[line_slot(a)];
            m_valid[w][idx] = 1'b1;
            m_dirty[w][idx] = 1'b0;
            m_tag[w][idx]   = tg;
        end
        rd = m_line[w][idx][off*WORD_W +: WORD_W];
        if (we) begin
            m_line[w][idx][off*WORD_W +: WORD_W] = wd;
            m_dirty[w][idx] = 1'b1;
        end
        m_lru[idx] = ~w;  // replay counts as a hit
    endtask

    task automatic cpu_access(input string name, input addr_t a, input logic we, input word_t wd);
        word_t exp_rd;
        logic  exp_hit;
        int    lat;
        model_access(a, we, wd, exp_rd, exp_hit);
        touched[(a - MEM_BASE) >> BYTE_W] = 1'b1;
        if (cpu_ack) begin
            protocol_error("cpu_ack is high before the request starts");
        end
        cpu_addr  = a;
        cpu_we    = we;
        cpu_wdata = wd;
        cpu_req   = 1'b1;
        lat       = 0;
        while (!cpu_ack) begin
            @(negedge clk);
            lat++;
        end
        if (!we) begin
            check_word(name, exp_rd, cpu_rdata);
        end
        if (exp_hit) begin
            check_word({name, " hit latency"}, word_t'(3), word_t'(lat - 1));
        end
        if (exp_we.size() != 0) begin
            protocol_error("cpu_ack came before the expected memory transactions");
        end
        cpu_req = 1'b0;
        while (cpu_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic serve_mem();
        logic  we;
        addr_t a;
        line_t l;
        int    d_ack;
        int    d_rel;
        int    slot;
        if (exp_we.size() == 0) begin
            protocol_error("memory request where the model expects none");
        end
        we    = exp_we.pop_front();
        a     = exp_addr.pop_front();
        l     = exp_line.pop_front();
        d_ack = exp_d_ack.pop_front();
        d_rel = exp_d_rel.pop_front();
        if (mem_we !== we) begin
            protocol_error("memory transaction has the wrong direction");
        end
        if (we) begin
            check_addr("write-back address", a, mem_addr);
            check_line("write-back line", l, mem_wdata);
        end else begin
            check_addr("fill address", a, mem_addr);
        end
        slot = line_slot(mem_addr);
        repeat (d_ack) begin
            @(negedge clk);
            if (!mem_req) begin
                protocol_error("mem_req dropped before mem_ack was raised");
            end
        end
        if (we) begin
            mem_lines[slot] = mem_wdata;
        end else begin
            mem_rdata = mem_lines[slot];
        end
        mem_ack = 1'b1;
        @(negedge clk);
        while (mem_req) begin
            @(negedge clk);
        end
        repeat (d_rel) begin
            @(negedge clk);
            if (mem_req) begin
                protocol_error("new mem_req raised while mem_ack is still high");
            end
        end
        mem_ack = 1'b0;
    endtask

    // memory responder
    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1) begin
                serve_mem();
            end
        end
    end

    initial begin
        int   widx;
        logic we;
        clk       = 1'b0;
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        lcg_state = 32'd58;
        touched   = '0;
        for (int s = 0; s < WINDOW_LINES; s++) begin
            mem_lines[s] = fill_line(MEM_BASE + addr_t'(s * LINE_WORDS * 4));
            ref_mem[s]   = fill_line(MEM_BASE + addr_t'(s * LINE_WORDS * 4));
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            m_lru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 4; i++) begin
            cpu_access("cold read", word_addr(i * 20 + 1), 1'b0, '0);  // four different sets
        end

        cpu_access("write word", word_addr(42), 1'b1, 32'hcafe_0042);
        cpu_access("read back", word_addr(42), 1'b0, '0);
        cpu_access("neighbour word 0", word_addr(40), 1'b0, '0);
        cpu_access("neighbour word 1", word_addr(41), 1'b0, '0);
        cpu_access("neighbour word 3", word_addr(43), 1'b0, '0);

        // lines 3, 19 and 35 share set 3
        cpu_access("dirty line a", word_addr(3 * 4), 1'b1, 32'h1111_aaaa);
        cpu_access("dirty line b", word_addr(19 * 4 + 1), 1'b1, 32'h2222_bbbb);
        cpu_access("evict line a", word_addr(35 * 4 + 2), 1'b0, '0);
        cpu_access("reload line a", word_addr(3 * 4), 1'b0, '0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            widx = rand_below(WINDOW_WORDS);
            we   = rand_below(2) == 1;
            if (we) begin
                cpu_access("random write", word_addr(widx), 1'b1, lcg_next());
            end else begin
                cpu_access("random read", word_addr(widx), 1'b0, '0);
            end
        end

        for (int i = 0; i < WINDOW_WORDS; i++) begin
            if (touched[i]) begin
                cpu_access("final read", word_addr(i), 1'b0, '0);
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
// data cache top level, joins controller, both ways and lookup behind plain cpu and memory ports
`default_nettype none
`timescale 1ns/1ns

module dcache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_req,
    input  logic                   cpu_we,
    input  dcache_geom_pkg::addr_t cpu_addr,
    input  dcache_geom_pkg::word_t cpu_wdata,
    output logic                   cpu_ack,
    output dcache_geom_pkg::word_t cpu_rdata,
    output logic                   mem_req,
    output logic                   mem_we,
    output dcache_geom_pkg::addr_t mem_addr,
    output dcache_geom_pkg::line_t mem_wdata,
    input  logic                   mem_ack,
    input  dcache_geom_pkg::line_t mem_rdata
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    way_if       ways [NUM_WAYS] ();
    lookup_res_t res;
    way_t        lru;

    dcache_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .ways      (ways),
        .res       (res),
        .lru       (lru)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        dcache_way u_way (
            .clk   (clk),
            .reset (reset),
            .wif   (ways[g])
        );
    end

    dcache_lookup u_lookup (
        .ways      (ways),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .lru       (lru),
        .res       (res)
    );

endmodule

`default_nettype wire

// ==== dcache_way.sv ====
// one cache way with per-set valid, dirty and tag, its data array and its own tag compare
`default_nettype none
`timescale 1ns/1ns

module dcache_way (
    input logic clk,
    input logic reset,
    way_if.way  wif
);
    import dcache_geom_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    tag_t                tag_q [NUM_SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (wif.wr_en) begin
            valid_q[wif.index] <= 1'b1;  // any write fills the line
        end
    end

    always_ff @(posedge clk) begin
        if (wif.wr_en) begin
            dirty_q[wif.index] <= wif.wr_dirty;
            tag_q[wif.index]   <= wif.wr_tag;
        end
    end

    // state read is write-first and lines up with the data array
    always_ff @(posedge clk) begin
        if (reset) begin
            wif.rd_valid <= 1'b0;
        end else if (wif.wr_en) begin
            wif.rd_valid <= 1'b1;
        end else begin
            wif.rd_valid <= valid_q[wif.index];
        end
    end

    always_ff @(posedge clk) begin
        if (wif.wr_en) begin
            wif.rd_dirty <= wif.wr_dirty;
            wif.rd_tag   <= wif.wr_tag;
        end else begin
            wif.rd_dirty <= dirty_q[wif.index];
            wif.rd_tag   <= tag_q[wif.index];
        end
    end

    assign wif.match = wif.rd_valid && (wif.rd_tag == wif.req_tag);

    dcache_ram #(
        .payload_t (line_t),
        .DEPTH     (NUM_SETS)
    ) u_data (
        .clk     (clk),
        .addr    (wif.index),
        .wr_en   (wif.wr_en),
        .wr_data (wif.wr_line),
        .rd_data (wif.rd_line)
    );

endmodule

`default_nettype wire

// ==== way_if.sv ====
// one cache way's index, write controls and registered read results, one instance per way
`default_nettype none
`timescale 1ns/1ns

interface way_if;
    import dcache_geom_pkg::*;

    index_t index;     // set of the current cpu access
    tag_t   req_tag;   // tag of the current cpu access
    logic   wr_en;     // write sets valid as well
    tag_t   wr_tag;
    logic   wr_dirty;
    line_t  wr_line;

    logic   rd_valid;
    logic   rd_dirty;
    tag_t   rd_tag;
    line_t  rd_line;
    logic   match;     // valid and tag equal

    modport ctrl (output index, req_tag, wr_en, wr_tag, wr_dirty, wr_line);

    modport way (input index, req_tag, wr_en, wr_tag, wr_dirty, wr_line,
                 output rd_valid, rd_dirty, rd_tag, rd_line, match);

    modport lookup (input rd_valid, rd_dirty, rd_tag, rd_line, match);

endinterface

`default_nettype wire
